// File: logic/periph_pkg.sv
`default_nettype none

package periph_pkg;

   localparam int DATA_W = 32;                   // Bus data word
   localparam int ADDR_W = 32;                   // Bus address

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;

   // 4-bit peripheral field sits at addr[15:12]
   localparam int PERIPH_SEL_LSB = 12;

   typedef enum logic [3:0] {
      PERIPH_GPIO    = 4'd0,
      PERIPH_CPUCTRL = 4'd1,
      PERIPH_INTC    = 4'd2                      // Other codes hit nothing
   } periph_idx_t;

   typedef logic [1:0] reg_off_t;                // Word index, addr[3:2]

   localparam reg_off_t REG_GPIO_OUT     = 2'd0;
   localparam reg_off_t REG_GPIO_IN      = 2'd1;
   localparam reg_off_t REG_GPIO_IRQ_EN  = 2'd2;

   localparam reg_off_t REG_CPUCTRL      = 2'd0;

   localparam reg_off_t REG_INTC_PENDING = 2'd0; // Write 1 to clear
   localparam reg_off_t REG_INTC_MASK    = 2'd1;

   localparam int NUM_IRQ = 2;                   // 0 GPIO, 1 external

   typedef logic [NUM_IRQ-1:0] irq_vec_t;

endpackage

`default_nettype wire

// File: logic/apb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface apb_if;
   import periph_pkg::*;

   addr_t paddr;                                 // Full address, slave picks its bits
   logic  psel;
   logic  penable;                               // High in access cycle
   logic  pwrite;
   data_t pwdata;
   data_t prdata;                                // Zero while not selected

   modport master (
      output paddr,
      output psel,
      output penable,
      output pwrite,
      output pwdata,
      input  prdata
   );

   modport slave (
      input  paddr,
      input  psel,
      input  penable,
      input  pwrite,
      input  pwdata,
      output prdata
   );

endinterface

`default_nettype wire

// File: logic/ahb_apb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_apb_bridge (
   input  wire                    clk,
   input  wire                    rst_i,
   input  wire                    ahb_sel_i,
   input  wire                    ahb_write_i,
   input  wire periph_pkg::addr_t ahb_addr_i,
   input  wire periph_pkg::data_t ahb_wdata_i,
   output logic                   ahb_ready_o,
   output periph_pkg::data_t      ahb_rdata_o,
   apb_if.master                  apb_gpio,
   apb_if.master                  apb_cpuctrl,
   apb_if.master                  apb_intc
);
   import periph_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SETUP,
      ST_ACCESS
   } state_t;

   state_t      state_q;                         // APB phase
   addr_t       addr_q;                          // Captured address phase
   logic        write_q;
   data_t       wdata_q;                         // Write data comes with the address
   periph_idx_t idx;                             // Decoded peripheral field
   logic        busy;                            // Setup or access
   logic        access;
   logic        sel_gpio;
   logic        sel_cpuctrl;
   logic        sel_intc;
   data_t       rd_mux;

   assign idx    = periph_idx_t'(addr_q[PERIPH_SEL_LSB +: $bits(periph_idx_t)]);
   assign busy   = (state_q != ST_IDLE);
   assign access = (state_q == ST_ACCESS);

   assign ahb_ready_o = ~busy;                   // Low for exactly setup and access

   // Unmapped index leaves every select low
   assign sel_gpio    = (idx == PERIPH_GPIO);
   assign sel_cpuctrl = (idx == PERIPH_CPUCTRL);
   assign sel_intc    = (idx == PERIPH_INTC);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (ahb_sel_i) begin
                  state_q <= ST_SETUP;
               end
            end
            ST_SETUP: state_q <= ST_ACCESS;
            default:  state_q <= ST_IDLE;        // Access done, back to idle
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ahb_sel_i && ahb_ready_o) begin        // Address phase accepted
         addr_q  <= ahb_addr_i;
         write_q <= ahb_write_i;
         wdata_q <= ahb_wdata_i;
      end
   end

   // Shared request lines, only psel is steered
   assign apb_gpio.paddr    = addr_q;
   assign apb_gpio.pwrite   = write_q;
   assign apb_gpio.pwdata   = wdata_q;
   assign apb_gpio.psel     = busy & sel_gpio;
   assign apb_gpio.penable  = access & sel_gpio;

   assign apb_cpuctrl.paddr   = addr_q;
   assign apb_cpuctrl.pwrite  = write_q;
   assign apb_cpuctrl.pwdata  = wdata_q;
   assign apb_cpuctrl.psel    = busy & sel_cpuctrl;
   assign apb_cpuctrl.penable = access & sel_cpuctrl;

   assign apb_intc.paddr    = addr_q;
   assign apb_intc.pwrite   = write_q;
   assign apb_intc.pwdata   = wdata_q;
   assign apb_intc.psel     = busy & sel_intc;
   assign apb_intc.penable  = access & sel_intc;

   always_comb begin
      case (idx)
         PERIPH_GPIO:    rd_mux = apb_gpio.prdata;
         PERIPH_CPUCTRL: rd_mux = apb_cpuctrl.prdata;
         PERIPH_INTC:    rd_mux = apb_intc.prdata;
         default:        rd_mux = '0;            // Unmapped reads as zero
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ahb_rdata_o <= '0;
      end else if (access) begin                 // Completion, held until the next one
         ahb_rdata_o <= write_q ? '0 : rd_mux;
      end
   end

   // Host holds off while a transfer is in flight
   a_sel_only_ready: assert property (@(posedge clk) disable iff (rst_i)
      ahb_sel_i |-> ahb_ready_o);

   a_psel_onehot: assert property (@(posedge clk) disable iff (rst_i)
      $onehot0({apb_gpio.psel, apb_cpuctrl.psel, apb_intc.psel}));

endmodule

`default_nettype wire

// File: logic/gpio_apb.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_apb #(
   parameter int GPIO_WIDTH = 16
) (
   input  wire                   clk,
   input  wire                   rst_i,
   input  wire  [GPIO_WIDTH-1:0] gpio_in_i,
   output logic [GPIO_WIDTH-1:0] gpio_out_o,
   output logic                  gpio_irq_o,
   apb_if.slave                  apb
);
   import periph_pkg::*;

   logic [GPIO_WIDTH-1:0] irq_en_q;              // Per-bit change enable
   logic [GPIO_WIDTH-1:0] sync1_q;               // First synchronizer stage
   logic [GPIO_WIDTH-1:0] sync2_q;               // Safe to use from here
   logic [GPIO_WIDTH-1:0] prev_q;                // sync2 one cycle late
   logic [GPIO_WIDTH-1:0] change;
   reg_off_t              off;
   logic                  wr_en;

   assign off    = apb.paddr[3:2];
   assign wr_en  = apb.psel & apb.penable & apb.pwrite;
   assign change = (sync2_q ^ prev_q) & irq_en_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         gpio_out_o <= '0;
         irq_en_q   <= '0;
      end else if (wr_en) begin
         case (off)
            REG_GPIO_OUT:    gpio_out_o <= apb.pwdata[GPIO_WIDTH-1:0];
            REG_GPIO_IRQ_EN: irq_en_q   <= apb.pwdata[GPIO_WIDTH-1:0];
            default: ;                           // IN is read only
         endcase
      end
   end

   always_ff @(posedge clk) begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         gpio_irq_o <= 1'b0;
      end else begin
         gpio_irq_o <= (|change) & ~gpio_irq_o;  // Back-to-back changes merge
      end
   end

   always_comb begin
      apb.prdata = '0;
      if (apb.psel) begin
         case (off)
            REG_GPIO_OUT:    apb.prdata = DATA_W'(gpio_out_o);
            REG_GPIO_IN:     apb.prdata = DATA_W'(sync2_q);
            REG_GPIO_IRQ_EN: apb.prdata = DATA_W'(irq_en_q);
            default:         apb.prdata = '0;
         endcase
      end
   end

   // Interrupt controller edge-detects this line
   a_irq_pulse: assert property (@(posedge clk) disable iff (rst_i)
      gpio_irq_o |=> !gpio_irq_o);

endmodule

`default_nettype wire

// File: logic/cpuctrl_apb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuctrl_apb (
   input  wire  clk,
   input  wire  rst_i,
   output logic soft_rst_o,
   apb_if.slave apb
);
   import periph_pkg::*;

   localparam int CTRL_W = 16;

   logic [CTRL_W-1:0] ctrl_q;                    // Bit 0 holds the CPU in reset
   reg_off_t          off;
   logic              wr_en;

   assign off   = apb.paddr[3:2];
   assign wr_en = apb.psel & apb.penable & apb.pwrite;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ctrl_q <= '0;
      end else if (wr_en && off == REG_CPUCTRL) begin
         ctrl_q <= apb.pwdata[CTRL_W-1:0];       // Upper word bits dropped
      end
   end

   assign soft_rst_o = ctrl_q[0];

   always_comb begin
      apb.prdata = '0;
      if (apb.psel && off == REG_CPUCTRL) begin
         apb.prdata = DATA_W'(ctrl_q);
      end
   end

endmodule

`default_nettype wire

// File: logic/reset_generator.sv
`timescale 1ns/1ps
`default_nettype none

module reset_generator #(
   parameter int RST_CYCLES = 8
) (
   input  wire  clk,
   input  wire  rst_i,
   input  wire  soft_rst_i,
   output logic cpu_rst_o
);

   localparam int CNT_W = $clog2(RST_CYCLES + 1);

   logic [CNT_W-1:0] cnt_q;                      // Cycles of stretch left
   logic             any_rst;

   assign any_rst = rst_i | soft_rst_i;

   always_ff @(posedge clk) begin
      if (any_rst) begin
         cnt_q <= CNT_W'(RST_CYCLES);            // Reload while a source is held
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // Sources feed through so the CPU sees reset in the same cycle
   assign cpu_rst_o = any_rst | (cnt_q != '0);

   a_rst_covers: assert property (@(posedge clk)
      $past(rst_i) |-> cpu_rst_o);

endmodule

`default_nettype wire

// File: logic/intc_apb.sv
`timescale 1ns/1ps
`default_nettype none

module intc_apb (
   input  wire                       clk,
   input  wire                       rst_i,
   input  wire periph_pkg::irq_vec_t irq_src_i,
   input  wire                       irq_ack_i,
   output logic                      irq_o,
   apb_if.slave                      apb
);
   import periph_pkg::*;

   localparam irq_vec_t EDGE_SRC = 2'b01;        // GPIO pulses, external is a level

   irq_vec_t pending_q;
   irq_vec_t mask_q;
   irq_vec_t src_q;                              // Sources one cycle late
   irq_vec_t set;
   irq_vec_t active;                             // Pending and unmasked
   irq_vec_t ack_clr;
   irq_vec_t wr_clr;
   reg_off_t off;
   logic     wr_en;

   assign off    = apb.paddr[3:2];
   assign wr_en  = apb.psel & apb.penable & apb.pwrite;
   assign set    = (irq_src_i & ~src_q & EDGE_SRC) | (irq_src_i & ~EDGE_SRC);
   assign active = pending_q & mask_q;

   // Lowest set bit of active
   assign ack_clr = irq_ack_i ? (active & irq_vec_t'(~active + 1'b1)) : '0;
   assign wr_clr  = (wr_en && off == REG_INTC_PENDING) ? apb.pwdata[NUM_IRQ-1:0] : '0;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         src_q     <= '0;
         pending_q <= '0;
         irq_o     <= 1'b0;
      end else begin
         src_q     <= irq_src_i;
         pending_q <= (pending_q & ~wr_clr & ~ack_clr) | set;  // New request wins
         irq_o     <= |active;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         mask_q <= '0;
      end else if (wr_en && off == REG_INTC_MASK) begin
         mask_q <= apb.pwdata[NUM_IRQ-1:0];
      end
   end

   always_comb begin
      apb.prdata = '0;
      if (apb.psel) begin
         case (off)
            REG_INTC_PENDING: apb.prdata = DATA_W'(pending_q);
            REG_INTC_MASK:    apb.prdata = DATA_W'(mask_q);
            default:          apb.prdata = '0;
         endcase
      end
   end

   a_no_rise_unmasked: assert property (@(posedge clk) disable iff (rst_i)
      $rose(irq_o) |-> $past(mask_q) != '0);

endmodule

`default_nettype wire

// File: logic/periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top #(
   parameter int GPIO_WIDTH = 16,
   parameter int RST_CYCLES = 8
) (
   input  wire                    clk,
   input  wire                    rst_i,
   input  wire                    ahb_sel_i,
   input  wire                    ahb_write_i,
   input  wire periph_pkg::addr_t ahb_addr_i,
   input  wire periph_pkg::data_t ahb_wdata_i,
   input  wire [GPIO_WIDTH-1:0]   gpio_in_i,
   input  wire                    irq_ext_i,
   input  wire                    irq_ack_i,
   output logic                   ahb_ready_o,
   output periph_pkg::data_t      ahb_rdata_o,
   output logic [GPIO_WIDTH-1:0]  gpio_out_o,
   output logic                   irq_o,
   output logic                   cpu_rst_o
);
   import periph_pkg::*;

   logic     gpio_irq;
   logic     soft_rst;                           // CTRL bit 0
   irq_vec_t irq_src;

   apb_if apb_gpio ();
   apb_if apb_cpuctrl ();
   apb_if apb_intc ();

   assign irq_src = {irq_ext_i, gpio_irq};       // Source 0 GPIO, 1 external

   ahb_apb_bridge u_bridge (
      .clk         (clk),
      .rst_i       (rst_i),
      .ahb_sel_i   (ahb_sel_i),
      .ahb_write_i (ahb_write_i),
      .ahb_addr_i  (ahb_addr_i),
      .ahb_wdata_i (ahb_wdata_i),
      .ahb_ready_o (ahb_ready_o),
      .ahb_rdata_o (ahb_rdata_o),
      .apb_gpio    (apb_gpio.master),
      .apb_cpuctrl (apb_cpuctrl.master),
      .apb_intc    (apb_intc.master)
   );

   gpio_apb #(
      .GPIO_WIDTH (GPIO_WIDTH)
   ) u_gpio (
      .clk        (clk),
      .rst_i      (rst_i),
      .gpio_in_i  (gpio_in_i),
      .gpio_out_o (gpio_out_o),
      .gpio_irq_o (gpio_irq),
      .apb        (apb_gpio.slave)
   );

   cpuctrl_apb u_cpuctrl (
      .clk        (clk),
      .rst_i      (rst_i),
      .soft_rst_o (soft_rst),
      .apb        (apb_cpuctrl.slave)
   );

   reset_generator #(
      .RST_CYCLES (RST_CYCLES)
   ) u_reset_gen (
      .clk        (clk),
      .rst_i      (rst_i),
      .soft_rst_i (soft_rst),
      .cpu_rst_o  (cpu_rst_o)
   );

   intc_apb u_intc (
      .clk       (clk),
      .rst_i     (rst_i),
      .irq_src_i (irq_src),
      .irq_ack_i (irq_ack_i),
      .irq_o     (irq_o),
      .apb       (apb_intc.slave)
   );

endmodule

`default_nettype wire

// File: sim/periph_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top_tb;
   import periph_pkg::*;

   localparam int GPIO_WIDTH    = 16;
   localparam int RST_CYCLES    = 8;
   localparam int NUM_TRANSFERS = 300;
   localparam int CLK_NS        = 8;
   localparam int TIMEOUT_NS    = (NUM_TRANSFERS * 4 + 1000) * CLK_NS;  // Directed part in margin

   typedef logic [GPIO_WIDTH-1:0] gpio_t;

   logic  clk;
   logic  rst_i;
   logic  ahb_sel_i;
   logic  ahb_write_i;
   addr_t ahb_addr_i;
   data_t ahb_wdata_i;
   gpio_t gpio_in_i;
   logic  irq_ext_i;
   logic  irq_ack_i;
   logic  ahb_ready_o;
   data_t ahb_rdata_o;
   gpio_t gpio_out_o;
   logic  irq_o;
   logic  cpu_rst_o;

   integer      seed;
   gpio_t       m_out;                           // Register model
   gpio_t       m_irq_en;
   logic [15:0] m_ctrl;
   irq_vec_t    m_mask;
   irq_vec_t    m_pending;
   data_t       rd_data;                         // Last completed read

   periph_top #(
      .GPIO_WIDTH (GPIO_WIDTH),
      .RST_CYCLES (RST_CYCLES)
   ) uut (
      .clk         (clk),
      .rst_i       (rst_i),
      .ahb_sel_i   (ahb_sel_i),
      .ahb_write_i (ahb_write_i),
      .ahb_addr_i  (ahb_addr_i),
      .ahb_wdata_i (ahb_wdata_i),
      .gpio_in_i   (gpio_in_i),
      .irq_ext_i   (irq_ext_i),
      .irq_ack_i   (irq_ack_i),
      .ahb_ready_o (ahb_ready_o),
      .ahb_rdata_o (ahb_rdata_o),
      .gpio_out_o  (gpio_out_o),
      .irq_o       (irq_o),
      .cpu_rst_o   (cpu_rst_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired before all tests finished");
      $display("Test FAILED");
      $fatal(1, "timeout");
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_rdata(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_gpio_out(input string name, input gpio_t exp, input gpio_t act);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_irq(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic check_cpu_rst(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;                                        // Drive just after the edge
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   // Peripheral field and word index over random filler bits
   function automatic addr_t make_addr(input logic [3:0] idx, input reg_off_t off);
      addr_t a;
      a = $random(seed);
      a[PERIPH_SEL_LSB +: 4] = idx;
      a[3:2] = off;
      return a;
   endfunction

   task automatic bus_xfer(input logic wr, input addr_t addr, input data_t wdata);
      int cycles;
      if (ahb_ready_o !== 1'b1) begin
         abort_run("Host port was not ready when a transfer started");
      end
      ahb_sel_i   = 1'b1;
      ahb_write_i = wr;
      ahb_addr_i  = addr;
      ahb_wdata_i = wdata;
      next_cycle();
      ahb_sel_i = 1'b0;
      cycles = 1;
      while (ahb_ready_o !== 1'b1 && cycles < 8) begin  // Bounded wait for ready
         next_cycle();
         cycles++;
      end
      if (cycles != 3) begin
         abort_run($sformatf("Host ready came back after %0d cycles instead of 3", cycles));
      end
      rd_data = ahb_rdata_o;
   endtask

   // Expected word from the register map, zero-extended
   function automatic data_t model_read(input logic [3:0] idx, input reg_off_t off);
      data_t v;
      v = '0;
      case (idx)
         PERIPH_GPIO: begin
            case (off)
               REG_GPIO_OUT:    v = DATA_W'(m_out);
               REG_GPIO_IN:     v = DATA_W'(gpio_in_i);  // Settled input
               REG_GPIO_IRQ_EN: v = DATA_W'(m_irq_en);
               default:         v = '0;
            endcase
         end
         PERIPH_CPUCTRL: v = (off == REG_CPUCTRL) ? DATA_W'(m_ctrl) : '0;
         PERIPH_INTC: begin
            case (off)
               REG_INTC_PENDING: v = DATA_W'(m_pending);
               REG_INTC_MASK:    v = DATA_W'(m_mask);
               default:          v = '0;
            endcase
         end
         default: v = '0;                        // Unmapped
      endcase
      return v;
   endfunction

   function automatic void model_write(input logic [3:0] idx, input reg_off_t off,
                                       input data_t d);
      case ({idx, off})
         {PERIPH_GPIO, REG_GPIO_OUT}:        m_out     = d[GPIO_WIDTH-1:0];
         {PERIPH_GPIO, REG_GPIO_IRQ_EN}:     m_irq_en  = d[GPIO_WIDTH-1:0];
         {PERIPH_CPUCTRL, REG_CPUCTRL}:      m_ctrl    = d[15:0];
         {PERIPH_INTC, REG_INTC_PENDING}:    m_pending = m_pending & ~d[NUM_IRQ-1:0];
         {PERIPH_INTC, REG_INTC_MASK}:       m_mask    = d[NUM_IRQ-1:0];
         default: ;                              // Read only or unmapped
      endcase
   endfunction

   // Acknowledge drops the lowest source that is pending and enabled
   function automatic irq_vec_t ack_result(input irq_vec_t pend, input irq_vec_t mask);
      irq_vec_t r;
      r = pend;
      for (int i = 0; i < NUM_IRQ; i++) begin
         if (pend[i] && mask[i]) begin
            r[i] = 1'b0;
            break;
         end
      end
      return r;
   endfunction

   task automatic write_check(input logic [3:0] idx, input reg_off_t off, input data_t d);
      bus_xfer(1'b1, make_addr(idx, off), d);
      model_write(idx, off, d);
      check_gpio_out("gpio_out after write", m_out, gpio_out_o);
   endtask

   task automatic read_check(input string name, input logic [3:0] idx, input reg_off_t off);
      bus_xfer(1'b0, make_addr(idx, off), $random(seed));
      check_rdata(name, model_read(idx, off), rd_data);
      check_gpio_out("gpio_out after read", m_out, gpio_out_o);
   endtask

   task automatic pulse_ext();
      irq_ext_i = 1'b1;
      next_cycle();
      irq_ext_i = 1'b0;
      m_pending[1] = 1'b1;
      wait_cycles(1);                            // irq_o is one cycle behind pending
      check_irq("irq_o after external", |(m_pending & m_mask), irq_o);
      read_check("pending after external", PERIPH_INTC, REG_INTC_PENDING);
   endtask

   task automatic pulse_ack();
      irq_ack_i = 1'b1;
      next_cycle();
      irq_ack_i = 1'b0;
      m_pending = ack_result(m_pending, m_mask);
      wait_cycles(1);
      check_irq("irq_o after ack", |(m_pending & m_mask), irq_o);
      read_check("pending after ack", PERIPH_INTC, REG_INTC_PENDING);
   endtask

   // Stretch starts in the first cycle with both resets low
   task automatic check_stretch(input string name);
      for (int i = 0; i < RST_CYCLES; i++) begin
         check_cpu_rst(name, 1'b1, cpu_rst_o);
         next_cycle();
      end
      check_cpu_rst(name, 1'b0, cpu_rst_o);
   endtask

   initial begin : stimulus
      int         pick;
      logic [3:0] idx;
      reg_off_t   off;
      gpio_t      en;
      gpio_t      delta;
      seed        = 60975;
      rst_i       = 1'b1;
      ahb_sel_i   = 1'b0;
      ahb_write_i = 1'b0;
      ahb_addr_i  = '0;
      ahb_wdata_i = '0;
      irq_ext_i   = 1'b0;
      irq_ack_i   = 1'b0;
      gpio_in_i   = gpio_t'($random(seed));      // Held still until the GPIO tests
      m_out       = '0;
      m_irq_en    = '0;
      m_ctrl      = '0;
      m_mask      = '0;
      m_pending   = '0;
      wait_cycles(4);
      rst_i = 1'b0;
      check_stretch("cpu_rst after chip reset");
      check_gpio_out("gpio_out after reset", '0, gpio_out_o);

      for (int n = 0; n < NUM_TRANSFERS; n++) begin
         pick = {$random(seed)} % 4;
         idx  = (pick == 3) ? 4'(3 + {$random(seed)} % 13) : 4'(pick);  // 3 means unmapped
         off  = reg_off_t'($random(seed) & 3);
         if ($random(seed) & 1) begin
            write_check(idx, off, $random(seed));
         end else begin
            read_check("random read", idx, off);
         end
         check_irq("irq_o with no source", 1'b0, irq_o);
      end

      en    = gpio_t'($random(seed)) | gpio_t'(1);
      en[1] = 1'b0;                              // At least one bit each way
      write_check(PERIPH_GPIO, REG_GPIO_IRQ_EN, DATA_W'(en));
      write_check(PERIPH_INTC, REG_INTC_MASK, 32'h1);
      for (int k = 0; k < 6; k++) begin
         delta = gpio_t'($random(seed));
         if (k[0]) begin
            delta = (delta & ~en) | gpio_t'(2);  // Disabled bits only
         end else begin
            delta = (delta & en) | gpio_t'(1);
            m_pending[0] = 1'b1;
         end
         gpio_in_i = gpio_in_i ^ delta;
         wait_cycles(6);                         // Two flops, pulse, pending, irq_o
         read_check("gpio in after sync", PERIPH_GPIO, REG_GPIO_IN);
         read_check("pending after gpio change", PERIPH_INTC, REG_INTC_PENDING);
         check_irq("irq_o after gpio change", |(m_pending & m_mask), irq_o);
         write_check(PERIPH_INTC, REG_INTC_PENDING, DATA_W'(m_pending));
         wait_cycles(1);
         check_irq("irq_o after pending clear", 1'b0, irq_o);
      end

      write_check(PERIPH_INTC, REG_INTC_MASK, 32'h3);
      pulse_ext();
      gpio_in_i = gpio_in_i ^ gpio_t'(1);        // Bit 0 is enabled
      m_pending[0] = 1'b1;
      wait_cycles(6);
      read_check("pending with both sources", PERIPH_INTC, REG_INTC_PENDING);
      write_check(PERIPH_INTC, REG_INTC_MASK, 32'h2);
      pulse_ack();                               // Takes bit 1 since bit 0 is masked
      write_check(PERIPH_INTC, REG_INTC_MASK, 32'h3);
      pulse_ack();
      pulse_ack();                               // Nothing left to clear
      pulse_ext();
      write_check(PERIPH_INTC, REG_INTC_PENDING, 32'h2);
      wait_cycles(1);
      check_irq("irq_o after write-1 clear", 1'b0, irq_o);
      read_check("pending after write-1 clear", PERIPH_INTC, REG_INTC_PENDING);

      write_check(PERIPH_CPUCTRL, REG_CPUCTRL, 32'h0);
      wait_cycles(RST_CYCLES);                   // Any stretch from the random part is over
      check_cpu_rst("cpu_rst before soft reset", 1'b0, cpu_rst_o);
      write_check(PERIPH_CPUCTRL, REG_CPUCTRL, $random(seed) | 32'h1);
      check_cpu_rst("cpu_rst after soft reset set", 1'b1, cpu_rst_o);
      read_check("ctrl read back", PERIPH_CPUCTRL, REG_CPUCTRL);
      write_check(PERIPH_CPUCTRL, REG_CPUCTRL, $random(seed) & ~32'h1);
      check_stretch("cpu_rst after soft reset clear");
      read_check("ctrl read back", PERIPH_CPUCTRL, REG_CPUCTRL);

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
logic/periph_pkg.sv
logic/apb_if.sv
logic/ahb_apb_bridge.sv
logic/gpio_apb.sv
logic/cpuctrl_apb.sv
logic/reset_generator.sv
logic/intc_apb.sv
logic/periph_top.sv
sim/periph_top_tb.sv

// File: Makefile
# Verilator build and run of the peripheral subsystem testbench
TOP := periph_top_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f flist.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
